/* Makefile */
TOP := tb_issue_read_operands

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f issue_read_operands.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* issue_read_operands.f */
+incdir+include
rtl/isa_pkg.sv
rtl/issue_pkg.sv
rtl/issue_hazard_check.sv
rtl/operand_select.sv
rtl/int_regfile.sv
rtl/issue_ex_regs.sv
rtl/issue_read_operands.sv
test/tb_issue_read_operands.sv

/* rtl/int_regfile.sv */
/*
 * integer register file
 * two combinational reads, one write per commit port, x0 reads as zero
 */
module int_regfile #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  isa_pkg::reg_addr_t                            raddr_a_i,
    input  isa_pkg::reg_addr_t                            raddr_b_i,
    output isa_pkg::xlen_t                                rdata_a_o,
    output isa_pkg::xlen_t                                rdata_b_o,
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i
);

    import isa_pkg::*;

    xlen_t regs_q [NR_REGS];

    // ----------------------------------------------------------------------
    // write ports
    // ----------------------------------------------------------------------
    // ports are walked in order so the highest index wins a collision
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 0; r < NR_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
                // x0 is never written
                if (commit_i[i].we && commit_i[i].waddr != '0) begin
                    regs_q[commit_i[i].waddr] <= commit_i[i].wdata;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // read ports
    // ----------------------------------------------------------------------
    // hard-wired zero on x0
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* rtl/isa_pkg.sv */
/*
 * integer ISA definitions shared by the issue stage
 * data and register index widths, plus the operator encoding
 */
package isa_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    // integer data path width
    localparam int unsigned XLEN          = 32;
    // architectural register index
    localparam int unsigned REG_ADDR_BITS = 5;
    localparam int unsigned NR_REGS       = 2 ** REG_ADDR_BITS;
    // scoreboard slot id
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

    // ----------------------------------------------------------------------
    // operators
    // ----------------------------------------------------------------------
    // one byte wide so the encoding has room to grow
    typedef enum logic [7:0] {
        ADD,
        SUB,
        AND_OP,
        OR_OP,
        SLL,
        MUL,
        LW,
        SW,
        BEQ,
        JALR,
        CSRRW,
        CSRRS,
        SFENCE_VMA
    } fu_op_t;

endpackage

/* rtl/issue_ex_regs.sv */
/*
 * ID/EX pipeline register
 * holds the execute payload and raises one unit valid per accepted entry
 */
module issue_ex_regs (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  issue_pkg::issue_entry_t issue_instr_i,
    input  logic                    issue_valid_i,
    input  logic                    issue_ack_i,
    input  issue_pkg::fu_data_t     ex_next_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output isa_pkg::xlen_t          pc_o,
    output issue_pkg::fu_valid_t    fu_valid_o,
    // the multiplier holds the result bus next cycle
    output logic                    mult_issued_o
);

    import isa_pkg::*;
    import issue_pkg::*;

    fu_valid_t valid_d;

    // ----------------------------------------------------------------------
    // unit dispatch
    // ----------------------------------------------------------------------
    // an entry with an exception goes on without starting a unit
    always_comb begin : unit_dispatch
        valid_d = '0;
        if (issue_valid_i && issue_ack_i && !issue_instr_i.ex_valid) begin
            unique case (issue_instr_i.fu)
                ALU:         valid_d.alu    = 1'b1;
                CTRL_FLOW:   valid_d.branch = 1'b1;
                MULT:        valid_d.mult   = 1'b1;
                LOAD, STORE: valid_d.lsu    = 1'b1;
                CSR:         valid_d.csr    = 1'b1;
                default:     valid_d        = '0;
            endcase
        end
        // a flush kills whatever was about to start
        if (flush_i) begin
            valid_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_valid_o <= '0;
        end else begin
            fu_valid_o <= valid_d;
        end
    end

    assign mult_issued_o = fu_valid_o.mult;

    // payload follows the current entry every cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o.fu        <= NONE;
            fu_data_o.op        <= ADD;
            fu_data_o.operand_a <= '0;
            fu_data_o.operand_b <= '0;
            fu_data_o.imm       <= '0;
            fu_data_o.trans_id  <= '0;
            pc_o                <= '0;
        end else begin
            fu_data_o           <= ex_next_i;
            pc_o                <= issue_instr_i.pc;
        end
    end

    // ----------------------------------------------------------------------
    // assertions
    // ----------------------------------------------------------------------
    // at most one unit starts per cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(fu_valid_o))
        else $error("more than one unit valid");

    // nothing survives a flush
    assert property (@(posedge clk_i) disable iff (!rst_ni) flush_i |=> fu_valid_o == '0)
        else $error("unit valid after flush");

    // branch unit needs resolved operands
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fu_valid_o.branch |-> !$isunknown({fu_data_o.operand_a, fu_data_o.operand_b}))
        else $error("unknown operand on branch issue");

endmodule

/* rtl/issue_hazard_check.sv */
/*
 * issue hazard check
 * source availability, forwarding, unit busy, WAW and the issue acknowledge
 */
module issue_hazard_check #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  issue_pkg::issue_entry_t                       issue_instr_i,
    input  logic                                          issue_valid_i,
    input  logic                                          rs1_valid_i,
    input  logic                                          rs2_valid_i,
    input  issue_pkg::fu_t [isa_pkg::NR_REGS-1:0]         rd_clobber_i,
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                                          flu_ready_i,
    input  logic                                          lsu_ready_i,
    // a multiply went to execute last cycle
    input  logic                                          mult_issued_i,
    output logic                                          fwd_rs1_o,
    output logic                                          fwd_rs2_o,
    output logic                                          issue_ack_o
);

    import isa_pkg::*;
    import issue_pkg::*;

    logic stall;
    logic fu_busy;
    logic rd_free;
    fu_t  rs1_writer;
    fu_t  rs2_writer;

    assign rs1_writer = rd_clobber_i[issue_instr_i.rs1];
    assign rs2_writer = rd_clobber_i[issue_instr_i.rs2];

    // ----------------------------------------------------------------------
    // operand availability
    // ----------------------------------------------------------------------
    // a pending writer is forwarded once its result is valid
    // CSR results only come through the register file, except for sfence
    always_comb begin : operands_available
        stall     = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        // zimm replaces rs1 so there is nothing to wait on
        if (!issue_instr_i.use_zimm && rs1_writer != NONE) begin
            if (rs1_valid_i && (rs1_writer != CSR || issue_instr_i.op == SFENCE_VMA)) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_writer != NONE) begin
            if (rs2_valid_i && (rs2_writer != CSR || issue_instr_i.op == SFENCE_VMA)) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy flag of the unit this entry needs
    always_comb begin : unit_busy
        unique case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // WAW check
    // ----------------------------------------------------------------------
    // rd is free if nobody writes it or commit retires its writer right now
    always_comb begin : waw_check
        rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);
        for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
            if (commit_i[i].we && commit_i[i].waddr == issue_instr_i.rd) begin
                rd_free = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // acknowledge
    // ----------------------------------------------------------------------
    always_comb begin : issue_acknowledge
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less entries pass without any checks
            if (issue_instr_i.ex_valid || issue_instr_i.fu == NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        // the fixed latency result bus is taken by the multiplier
        if (mult_issued_i && issue_instr_i.fu != MULT) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

/* rtl/issue_pkg.sv */
/*
 * issue stage types
 * unit classes and the scoreboard, commit and execute payloads
 */
package issue_pkg;

    import isa_pkg::*;

    // functional unit classes, NONE marks a free register in the clobber table
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        MULT,
        LOAD,
        STORE,
        CSR
    } fu_t;

    // ----------------------------------------------------------------------
    // decoded instruction handed over by the scoreboard
    // ----------------------------------------------------------------------
    typedef struct packed {
        xlen_t                    pc;
        logic [TRANS_ID_BITS-1:0] trans_id;
        fu_t                      fu;
        fu_op_t                   op;
        reg_addr_t                rs1;
        reg_addr_t                rs2;
        reg_addr_t                rd;
        // holds the immediate
        xlen_t                    result;
        logic                     use_imm;
        logic                     use_pc;
        logic                     use_zimm;
        // exception already attached upstream
        logic                     ex_valid;
    } issue_entry_t;

    // one register write from commit
    typedef struct packed {
        reg_addr_t waddr;
        xlen_t     wdata;
        logic      we;
    } commit_port_t;

    // ----------------------------------------------------------------------
    // toward execute
    // ----------------------------------------------------------------------
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   op;
        xlen_t                    operand_a;
        xlen_t                    operand_b;
        xlen_t                    imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // one start strobe per unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } fu_valid_t;

endpackage

/* rtl/issue_read_operands.sv */
/*
 * integer issue and operand read stage
 * checks hazards, reads and forwards operands, registers them toward execute
 */
module issue_read_operands #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  logic                                          flush_i,
    // instruction from the scoreboard
    input  issue_pkg::issue_entry_t                       issue_instr_i,
    input  logic                                          issue_valid_i,
    output logic                                          issue_ack_o,
    // scoreboard lookup of pending results
    output isa_pkg::reg_addr_t                            rs1_o,
    output isa_pkg::reg_addr_t                            rs2_o,
    input  isa_pkg::xlen_t                                rs1_i,
    input  isa_pkg::xlen_t                                rs2_i,
    input  logic                                          rs1_valid_i,
    input  logic                                          rs2_valid_i,
    input  issue_pkg::fu_t [isa_pkg::NR_REGS-1:0]         rd_clobber_i,
    // register writes from commit
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    // unit readiness
    input  logic                                          flu_ready_i,
    input  logic                                          lsu_ready_i,
    // toward execute
    output issue_pkg::fu_data_t                           fu_data_o,
    output isa_pkg::xlen_t                                pc_o,
    output issue_pkg::fu_valid_t                          fu_valid_o
);

    import isa_pkg::*;
    import issue_pkg::*;

    logic     fwd_rs1;
    logic     fwd_rs2;
    logic     issue_ack;
    logic     mult_issued;
    xlen_t    rdata_a;
    xlen_t    rdata_b;
    fu_data_t ex_next;

    // scoreboard is polled with the source indices of the entry
    assign rs1_o       = issue_instr_i.rs1;
    assign rs2_o       = issue_instr_i.rs2;
    assign issue_ack_o = issue_ack;

    issue_hazard_check #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_issue_hazard_check (
        .issue_instr_i   ( issue_instr_i ),
        .issue_valid_i   ( issue_valid_i ),
        .rs1_valid_i     ( rs1_valid_i   ),
        .rs2_valid_i     ( rs2_valid_i   ),
        .rd_clobber_i    ( rd_clobber_i  ),
        .commit_i        ( commit_i      ),
        .flu_ready_i     ( flu_ready_i   ),
        .lsu_ready_i     ( lsu_ready_i   ),
        .mult_issued_i   ( mult_issued   ),
        .fwd_rs1_o       ( fwd_rs1       ),
        .fwd_rs2_o       ( fwd_rs2       ),
        .issue_ack_o     ( issue_ack     )
    );

    operand_select i_operand_select (
        .issue_instr_i ( issue_instr_i ),
        .rdata_a_i     ( rdata_a       ),
        .rdata_b_i     ( rdata_b       ),
        .rs1_i         ( rs1_i         ),
        .rs2_i         ( rs2_i         ),
        .fwd_rs1_i     ( fwd_rs1       ),
        .fwd_rs2_i     ( fwd_rs2       ),
        .ex_next_o     ( ex_next       )
    );

    int_regfile #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_int_regfile (
        .clk_i     ( clk_i             ),
        .rst_ni    ( rst_ni            ),
        .raddr_a_i ( issue_instr_i.rs1 ),
        .raddr_b_i ( issue_instr_i.rs2 ),
        .rdata_a_o ( rdata_a           ),
        .rdata_b_o ( rdata_b           ),
        .commit_i  ( commit_i          )
    );

    issue_ex_regs i_issue_ex_regs (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( flush_i       ),
        .issue_instr_i ( issue_instr_i ),
        .issue_valid_i ( issue_valid_i ),
        .issue_ack_i   ( issue_ack     ),
        .ex_next_i     ( ex_next       ),
        .fu_data_o     ( fu_data_o     ),
        .pc_o          ( pc_o          ),
        .fu_valid_o    ( fu_valid_o    ),
        .mult_issued_o ( mult_issued   )
    );

endmodule

/* rtl/operand_select.sv */
/*
 * operand select
 * picks register file, forwarded, PC, zimm or immediate operands for execute
 */
module operand_select (
    input  issue_pkg::issue_entry_t issue_instr_i,
    // register file read data
    input  isa_pkg::xlen_t          rdata_a_i,
    input  isa_pkg::xlen_t          rdata_b_i,
    // forwarded scoreboard results
    input  isa_pkg::xlen_t          rs1_i,
    input  isa_pkg::xlen_t          rs2_i,
    input  logic                    fwd_rs1_i,
    input  logic                    fwd_rs2_i,
    output issue_pkg::fu_data_t     ex_next_o
);

    import isa_pkg::*;
    import issue_pkg::*;

    always_comb begin : forwarding_operand_select
        ex_next_o.fu        = issue_instr_i.fu;
        ex_next_o.op        = issue_instr_i.op;
        ex_next_o.trans_id  = issue_instr_i.trans_id;
        ex_next_o.imm       = issue_instr_i.result;
        // default is the register file
        ex_next_o.operand_a = rdata_a_i;
        ex_next_o.operand_b = rdata_b_i;

        if (fwd_rs1_i) begin
            ex_next_o.operand_a = rs1_i;
        end
        if (fwd_rs2_i) begin
            ex_next_o.operand_b = rs2_i;
        end
        // auipc and jumps compute on the PC
        if (issue_instr_i.use_pc) begin
            ex_next_o.operand_a = issue_instr_i.pc;
        end
        // CSR immediate forms carry the zimm in the rs1 field
        if (issue_instr_i.use_zimm) begin
            ex_next_o.operand_a = {{(XLEN - REG_ADDR_BITS){1'b0}}, issue_instr_i.rs1};
        end
        // stores and branches keep rs2 and take the immediate through imm
        if (issue_instr_i.use_imm && issue_instr_i.fu != STORE &&
            issue_instr_i.fu != CTRL_FLOW) begin
            ex_next_o.operand_b = issue_instr_i.result;
        end
    end

endmodule

/* include/issue_tb_model.svh */
/*
 * reference model of the issue stage
 * register image, acknowledge rule and the expected execute payload
 */
`ifndef ISSUE_TB_MODEL_SVH
`define ISSUE_TB_MODEL_SVH

// register image as left behind by commit
xlen_t model_regs [NR_REGS];

// result of a pending writer can be taken from the scoreboard
function automatic logic can_forward(fu_t writer, logic result_valid, fu_op_t op);
    // CSR results are never forwarded, sfence only needs the value
    return writer != NONE && result_valid && (writer != CSR || op == SFENCE_VMA);
endfunction

function automatic logic source_blocked(fu_t writer, logic result_valid, fu_op_t op);
    return writer != NONE && !can_forward(writer, result_valid, op);
endfunction

function automatic logic predict_ack(issue_entry_t e, logic valid, fu_t [NR_REGS-1:0] clob,
        logic rs1_ok, logic rs2_ok, commit_port_t [NR_COMMIT_PORTS-1:0] commits,
        logic flu_ready, logic lsu_ready, logic mult_busy);
    logic blocked;
    logic busy;
    logic rd_free;
    blocked = source_blocked(clob[e.rs2], rs2_ok, e.op);
    // zimm forms do not read rs1
    if (!e.use_zimm) begin
        blocked |= source_blocked(clob[e.rs1], rs1_ok, e.op);
    end
    case (e.fu)
        LOAD, STORE: busy = !lsu_ready;
        NONE:        busy = 1'b0;
        default:     busy = !flu_ready;
    endcase
    // WAW clears when commit retires the old writer of rd this cycle
    rd_free = (clob[e.rd] == NONE);
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
        if (commits[i].we && commits[i].waddr == e.rd) begin
            rd_free = 1'b1;
        end
    end
    // result bus belongs to the multiplier one cycle after its issue
    if (mult_busy && e.fu != MULT) begin
        return 1'b0;
    end
    return valid && ((!blocked && !busy && rd_free) || e.ex_valid || e.fu == NONE);
endfunction

// unit strobe expected one cycle after the entry was seen
function automatic fu_valid_t predict_valid(issue_entry_t e, logic accepted, logic flush);
    fu_valid_t v;
    v = '0;
    if (accepted && !flush && !e.ex_valid) begin
        v.alu    = (e.fu == ALU);
        v.branch = (e.fu == CTRL_FLOW);
        v.lsu    = (e.fu == LOAD) || (e.fu == STORE);
        v.mult   = (e.fu == MULT);
        v.csr    = (e.fu == CSR);
    end
    return v;
endfunction

function automatic fu_data_t predict_data(issue_entry_t e, fu_t [NR_REGS-1:0] clob,
        logic rs1_ok, logic rs2_ok, xlen_t rs1_val, xlen_t rs2_val);
    fu_data_t d;
    d.fu       = e.fu;
    d.op       = e.op;
    d.imm      = e.result;
    d.trans_id = e.trans_id;
    // zimm beats PC, PC beats forwarding, forwarding beats the register image
    if (e.use_zimm) begin
        d.operand_a = xlen_t'(e.rs1);
    end else if (e.use_pc) begin
        d.operand_a = e.pc;
    end else if (can_forward(clob[e.rs1], rs1_ok, e.op)) begin
        d.operand_a = rs1_val;
    end else begin
        d.operand_a = model_regs[e.rs1];
    end
    // stores and branches never put the immediate on operand b
    if (e.use_imm && e.fu != STORE && e.fu != CTRL_FLOW) begin
        d.operand_b = e.result;
    end else if (can_forward(clob[e.rs2], rs2_ok, e.op)) begin
        d.operand_b = rs2_val;
    end else begin
        d.operand_b = model_regs[e.rs2];
    end
    return d;
endfunction

// commit writes land at the next edge, later ports win, x0 stays zero
task automatic apply_commits(commit_port_t [NR_COMMIT_PORTS-1:0] commits);
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
        if (commits[i].we && commits[i].waddr != '0) begin
            model_regs[commits[i].waddr] = commits[i].wdata;
        end
    end
endtask

`endif

/* test/tb_issue_read_operands.sv */
/*
 * testbench of the integer issue stage
 * seeded random scoreboard traffic checked against the reference model
 */
module tb_issue_read_operands;

    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;
    import issue_pkg::*;

    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned RESET_CYCLES    = 16;
    localparam int unsigned RUN_CYCLES      = 2000;
    // a quarter of margin on top of the random run
    localparam int unsigned TIMEOUT_CYCLES  = RUN_CYCLES + RUN_CYCLES / 4;

    logic                                clk_i;
    logic                                rst_ni;
    logic                                flush_i;
    issue_entry_t                        issue_instr_i;
    logic                                issue_valid_i;
    logic                                issue_ack_o;
    reg_addr_t                           rs1_o;
    reg_addr_t                           rs2_o;
    xlen_t                               rs1_i;
    xlen_t                               rs2_i;
    logic                                rs1_valid_i;
    logic                                rs2_valid_i;
    fu_t [NR_REGS-1:0]                   rd_clobber_i;
    commit_port_t [NR_COMMIT_PORTS-1:0]  commit_i;
    logic                                flu_ready_i;
    logic                                lsu_ready_i;
    fu_data_t                            fu_data_o;
    xlen_t                               pc_o;
    fu_valid_t                           fu_valid_o;

    // model state, expected outputs for the current cycle
    fu_valid_t exp_valid;
    fu_data_t  exp_data;
    xlen_t     exp_pc;
    logic      ack_model;
    logic      ack_seen;
    int        mismatch_count;
    int        protocol_errors;
    int        cycle_count;

    `include "issue_tb_model.svh"

    issue_read_operands #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) issue_read_operands_i (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( flush_i       ),
        .issue_instr_i ( issue_instr_i ),
        .issue_valid_i ( issue_valid_i ),
        .issue_ack_o   ( issue_ack_o   ),
        .rs1_o         ( rs1_o         ),
        .rs2_o         ( rs2_o         ),
        .rs1_i         ( rs1_i         ),
        .rs2_i         ( rs2_i         ),
        .rs1_valid_i   ( rs1_valid_i   ),
        .rs2_valid_i   ( rs2_valid_i   ),
        .rd_clobber_i  ( rd_clobber_i  ),
        .commit_i      ( commit_i      ),
        .flu_ready_i   ( flu_ready_i   ),
        .lsu_ready_i   ( lsu_ready_i   ),
        .fu_data_o     ( fu_data_o     ),
        .pc_o          ( pc_o          ),
        .fu_valid_o    ( fu_valid_o    )
    );

    always #50 clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    function automatic issue_entry_t random_entry();
        issue_entry_t e;
        e.pc       = $urandom();
        e.trans_id = TRANS_ID_BITS'($urandom());
        e.fu       = fu_t'($urandom_range(0, 6));
        e.op       = fu_op_t'($urandom_range(0, 12));
        e.rs1      = reg_addr_t'($urandom());
        e.rs2      = reg_addr_t'($urandom());
        e.rd       = reg_addr_t'($urandom());
        e.result   = $urandom();
        e.use_imm  = ($urandom_range(0, 1) == 1);
        e.use_pc   = ($urandom_range(0, 5) == 0);
        e.use_zimm = ($urandom_range(0, 7) == 0);
        e.ex_valid = ($urandom_range(0, 15) == 0);
        return e;
    endfunction

    task automatic drive_random_cycle();
        issue_entry_t                       entry;
        logic                               valid;
        fu_t [NR_REGS-1:0]                  clobber;
        commit_port_t [NR_COMMIT_PORTS-1:0] commits;
        entry = issue_instr_i;
        valid = issue_valid_i;
        // a waiting entry stays on the bus until acknowledged
        if (!(issue_valid_i && !ack_seen)) begin
            entry = random_entry();
            valid = ($urandom_range(0, 3) != 0);
        end
        // mostly free registers, x0 never has a writer
        for (int r = 0; r < NR_REGS; r++) begin
            clobber[r] = NONE;
            if (r != 0 && $urandom_range(0, 4) == 0) begin
                clobber[r] = fu_t'($urandom_range(1, 6));
            end
        end
        // some commits hit rd of the entry to open the WAW bypass
        for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
            commits[i].we    = ($urandom_range(0, 1) == 1);
            commits[i].wdata = $urandom();
            commits[i].waddr = reg_addr_t'($urandom());
            if ($urandom_range(0, 3) == 0) begin
                commits[i].waddr = entry.rd;
            end
        end
        issue_instr_i <= entry;
        issue_valid_i <= valid;
        rd_clobber_i  <= clobber;
        commit_i      <= commits;
        rs1_i         <= $urandom();
        rs2_i         <= $urandom();
        rs1_valid_i   <= ($urandom_range(0, 3) != 0);
        rs2_valid_i   <= ($urandom_range(0, 3) != 0);
        flu_ready_i   <= ($urandom_range(0, 7) != 0);
        lsu_ready_i   <= ($urandom_range(0, 7) != 0);
        flush_i       <= ($urandom_range(0, 31) == 0);
    endtask

    task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp);
        $display("MISMATCH %0t ns %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        mismatch_count++;
    endtask

    // ----------------------------------------------------------------------
    // checks at the falling edge, inputs and outputs are settled there
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (fu_valid_o !== exp_valid)
                report_mismatch("fu_valid_o", xlen_t'(fu_valid_o), xlen_t'(exp_valid));
            if (fu_data_o.fu !== exp_data.fu)
                report_mismatch("fu_data_o.fu", xlen_t'(fu_data_o.fu), xlen_t'(exp_data.fu));
            if (fu_data_o.op !== exp_data.op)
                report_mismatch("fu_data_o.op", xlen_t'(fu_data_o.op), xlen_t'(exp_data.op));
            if (fu_data_o.operand_a !== exp_data.operand_a)
                report_mismatch("fu_data_o.operand_a", fu_data_o.operand_a, exp_data.operand_a);
            if (fu_data_o.operand_b !== exp_data.operand_b)
                report_mismatch("fu_data_o.operand_b", fu_data_o.operand_b, exp_data.operand_b);
            if (fu_data_o.imm !== exp_data.imm)
                report_mismatch("fu_data_o.imm", fu_data_o.imm, exp_data.imm);
            if (fu_data_o.trans_id !== exp_data.trans_id)
                report_mismatch("fu_data_o.trans_id", xlen_t'(fu_data_o.trans_id),
                                xlen_t'(exp_data.trans_id));
            if (pc_o !== exp_pc)
                report_mismatch("pc_o", pc_o, exp_pc);
            // scoreboard lookup follows the source fields of the entry
            if (rs1_o !== issue_instr_i.rs1)
                report_mismatch("rs1_o", xlen_t'(rs1_o), xlen_t'(issue_instr_i.rs1));
            if (rs2_o !== issue_instr_i.rs2)
                report_mismatch("rs2_o", xlen_t'(rs2_o), xlen_t'(issue_instr_i.rs2));

            ack_model = predict_ack(issue_instr_i, issue_valid_i, rd_clobber_i, rs1_valid_i,
                                    rs2_valid_i, commit_i, flu_ready_i, lsu_ready_i,
                                    exp_valid.mult);
            if (issue_ack_o !== ack_model)
                report_mismatch("issue_ack_o", xlen_t'(issue_ack_o), xlen_t'(ack_model));
            // nothing but a multiply may follow a multiply
            if (exp_valid.mult && issue_instr_i.fu != MULT && issue_ack_o === 1'b1) begin
                $display("%0t ns: non-multiply entry acknowledged right after a multiply",
                         $time);
                protocol_errors++;
            end

            exp_valid = predict_valid(issue_instr_i, issue_valid_i && ack_model, flush_i);
            exp_data  = predict_data(issue_instr_i, rd_clobber_i, rs1_valid_i, rs2_valid_i,
                                     rs1_i, rs2_i);
            exp_pc    = issue_instr_i.pc;
            apply_commits(commit_i);
            ack_seen  = issue_ack_o;
        end
    end

    // run limit
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(35));
        clk_i           = 1'b0;
        rst_ni          = 1'b0;
        flush_i         = 1'b0;
        issue_instr_i   = '0;
        issue_valid_i   = 1'b0;
        rs1_i           = '0;
        rs2_i           = '0;
        rs1_valid_i     = 1'b0;
        rs2_valid_i     = 1'b0;
        rd_clobber_i    = '0;
        commit_i        = '0;
        flu_ready_i     = 1'b1;
        lsu_ready_i     = 1'b1;
        // reset values of the execute registers
        exp_valid       = '0;
        exp_data        = '0;
        exp_data.fu     = NONE;
        exp_data.op     = ADD;
        exp_pc          = '0;
        ack_seen        = 1'b0;
        mismatch_count  = 0;
        protocol_errors = 0;
        cycle_count     = 0;
        for (int r = 0; r < NR_REGS; r++) begin
            model_regs[r] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge clk_i);
            drive_random_cycle();
        end
        @(posedge clk_i);

        $display("errors: %0d mismatches, %0d protocol violations",
                 mismatch_count, protocol_errors);
        if (mismatch_count == 0 && protocol_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
